/* logic/mont_pkg.sv */
`default_nettype none

package mont_pkg;

    // operand width, kept small for short simulations
    localparam int WIDTH = 64;
    // headroom for 3m + 3b plus a sign bit
    localparam int ACC_W = WIDTH + 4;
    localparam int ACC_PAD = ACC_W - WIDTH;
    localparam int DIGIT_COUNT = WIDTH / 2;
    localparam int CNT_W = $clog2(DIGIT_COUNT);

    // multiple-select codes, a digit value maps straight onto 0..3
    localparam logic [2:0] SEL_ZERO = 3'd0;
    localparam logic [2:0] SEL_B    = 3'd1;
    localparam logic [2:0] SEL_2B   = 3'd2;
    localparam logic [2:0] SEL_3B   = 3'd3;
    localparam logic [2:0] SEL_M    = 3'd4;
    localparam logic [2:0] SEL_2M   = 3'd5;
    localparam logic [2:0] SEL_3M   = 3'd6;

    typedef struct packed {
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] m;
    } mont_operands_t;

    typedef struct packed {
        logic       adder_start;
        logic       subtract;
        logic       load_3m;
        logic       load_3b;
        logic       load_a;
        logic       shift_a;
        logic [2:0] sel;
        logic       precompute_src_b;
        logic       loop_mode;
        logic       shift_acc;
        logic       acc_en;
        logic       result_en;
    } mont_ctrl_t;

    // two's complement view after a subtraction
    typedef struct packed {
        logic             neg;
        logic [ACC_W-2:0] mag;
    } acc_diff_t;

    typedef union packed {
        logic [ACC_W-1:0] word;
        acc_diff_t        diff;
    } acc_word_u;

endpackage

`default_nettype wire

/* logic/mp_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module mp_adder (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       start,
    input  wire                       subtract,
    input  wire [mont_pkg::ACC_W-1:0] op_a,
    input  wire [mont_pkg::ACC_W-1:0] op_b,
    output mont_pkg::acc_word_u       sum,
    output logic                      adder_done
);
    import mont_pkg::*;

    localparam int LO_W = ACC_W / 2;
    localparam int HI_W = ACC_W - LO_W;

    logic [LO_W:0]   lo_sum;
    logic [HI_W-1:0] hi_sum;
    logic [LO_W-1:0] lo_q;
    logic            carry_q;
    logic            sub_q;
    logic            hi_pending;

    // subtract as a + ~b + 1, carry-in on the low half
    assign lo_sum = {1'b0, op_a[LO_W-1:0]}
                  + {1'b0, op_b[LO_W-1:0] ^ {LO_W{subtract}}}
                  + (LO_W + 1)'(subtract);

    // upper half in the second cycle, operands still held
    assign hi_sum = op_a[ACC_W-1:LO_W]
                  + (op_b[ACC_W-1:LO_W] ^ {HI_W{sub_q}})
                  + HI_W'(carry_q);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            hi_pending <= 1'b0;
            adder_done <= 1'b0;
        end else begin
            hi_pending <= start;
            adder_done <= hi_pending;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            lo_q    <= lo_sum[LO_W-1:0];
            carry_q <= lo_sum[LO_W];
            sub_q   <= subtract;
        end
        if (hi_pending) begin
            sum.word <= {hi_sum, lo_q};
        end
    end

endmodule

`default_nettype wire

/* logic/multiple_table.sv */
`timescale 1ns/1ps
`default_nettype none

module multiple_table (
    input  wire                        clk,
    input  wire mont_pkg::mont_ctrl_t  ctrl,
    input  wire [mont_pkg::WIDTH-1:0]  b,
    input  wire [mont_pkg::WIDTH-1:0]  m,
    input  wire mont_pkg::acc_word_u   sum,
    output logic [mont_pkg::ACC_W-1:0] multiple
);
    import mont_pkg::*;

    logic [ACC_W-1:0] one_b;
    logic [ACC_W-1:0] two_b;
    logic [ACC_W-1:0] three_b;
    logic [ACC_W-1:0] one_m;
    logic [ACC_W-1:0] two_m;
    logic [ACC_W-1:0] three_m;

    // single and double multiples need no storage
    assign one_b = {{ACC_PAD{1'b0}}, b};
    assign two_b = {{(ACC_PAD - 1){1'b0}}, b, 1'b0};
    assign one_m = {{ACC_PAD{1'b0}}, m};
    assign two_m = {{(ACC_PAD - 1){1'b0}}, m, 1'b0};

    // triples captured from the adder during precompute
    always_ff @(posedge clk) begin
        if (ctrl.load_3m) begin
            three_m <= sum.word;
        end
        if (ctrl.load_3b) begin
            three_b <= sum.word;
        end
    end

    always_comb begin
        case (ctrl.sel)
            SEL_B: begin
                multiple = one_b;
            end
            SEL_2B: begin
                multiple = two_b;
            end
            SEL_3B: begin
                multiple = three_b;
            end
            SEL_M: begin
                multiple = one_m;
            end
            SEL_2M: begin
                multiple = two_m;
            end
            SEL_3M: begin
                multiple = three_m;
            end
            default: begin
                multiple = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/mont_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_datapath (
    input  wire                           clk,
    input  wire mont_pkg::mont_ctrl_t     ctrl,
    input  wire mont_pkg::mont_operands_t ops,
    input  wire [mont_pkg::ACC_W-1:0]     multiple,
    input  wire mont_pkg::acc_word_u      sum,
    output logic [mont_pkg::ACC_W-1:0]    op_a,
    output logic [mont_pkg::ACC_W-1:0]    op_b,
    output logic [1:0]                    digit,
    output logic [1:0]                    acc_low,
    output logic [mont_pkg::WIDTH-1:0]    result
);
    import mont_pkg::*;

    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] pre_src;
    logic [ACC_W-1:0] acc_view;

    // m first, then b, each added to its own double
    assign pre_src = ctrl.precompute_src_b ? ops.b : ops.m;

    // divide by 4 once the low two bits have been cleared
    assign acc_view = ctrl.shift_acc ? {2'b00, sum.word[ACC_W-1:2]} : sum.word;

    always_comb begin
        if (ctrl.loop_mode) begin
            // acc_en low starts the first digit from zero
            op_a = ctrl.acc_en ? acc_view : '0;
            op_b = multiple;
        end else begin
            op_a = {{ACC_PAD{1'b0}}, pre_src};
            op_b = {{(ACC_PAD - 1){1'b0}}, pre_src, 1'b0};
        end
    end

    // reduction choice looks at the operand actually fed in
    assign acc_low = op_a[1:0];
    assign digit = a_q[1:0];

    // a consumed lsb first, two bits per digit
    always_ff @(posedge clk) begin
        if (ctrl.load_a) begin
            a_q <= ops.a;
        end else if (ctrl.shift_a) begin
            a_q <= {2'b00, a_q[WIDTH-1:2]};
        end
    end

    // fully reduced value fits in the low WIDTH bits
    always_ff @(posedge clk) begin
        if (ctrl.result_en) begin
            result <= sum.word[WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

/* logic/mont_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_ctrl (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      start,
    input  wire [1:0]                digit,
    input  wire [1:0]                m_low,
    input  wire [1:0]                acc_low,
    input  wire mont_pkg::acc_word_u sum,
    input  wire                      adder_done,
    output mont_pkg::mont_ctrl_t     ctrl,
    output logic                     done
);
    import mont_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_PRE_3M,
        S_PRE_3B,
        S_DIGIT,
        S_REDUCE,
        S_SUB_FIRST,
        S_SUB,
        S_ADD_BACK,
        S_FINISH
    } state_t;

    state_t           state;
    state_t           state_next;
    logic             in_flight;
    logic             launch;
    logic [CNT_W-1:0] count;
    logic [1:0]       red_prod;
    logic [2:0]       red_sel;

    // multiple of m that clears the low two accumulator bits
    assign red_prod = acc_low * m_low;

    always_comb begin
        if (acc_low == 2'd0) begin
            red_sel = SEL_ZERO;
        end else if (acc_low == 2'd2) begin
            red_sel = SEL_2M;
        end else if (red_prod == 2'd1) begin
            red_sel = SEL_3M;
        end else begin
            red_sel = SEL_M;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (start) state_next = S_PRE_3M;
            end
            S_PRE_3M: begin
                if (adder_done) state_next = S_PRE_3B;
            end
            S_PRE_3B: begin
                if (adder_done) state_next = S_DIGIT;
            end
            S_DIGIT: begin
                if (adder_done) state_next = S_REDUCE;
            end
            S_REDUCE: begin
                if (adder_done) begin
                    state_next = (count == CNT_W'(DIGIT_COUNT - 1)) ? S_SUB_FIRST : S_DIGIT;
                end
            end
            S_SUB_FIRST, S_SUB: begin
                // went negative, one m too many
                if (adder_done) state_next = sum.diff.neg ? S_ADD_BACK : S_SUB;
            end
            S_ADD_BACK: begin
                if (adder_done) state_next = S_FINISH;
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    // one addition per state visit, launched on entry
    assign launch = (state != S_IDLE) && (state != S_FINISH) && !in_flight;

    always_comb begin
        ctrl = '0;
        ctrl.adder_start = launch;
        case (state)
            S_PRE_3M: begin
                ctrl.load_a  = launch;
                ctrl.load_3m = adder_done;
            end
            S_PRE_3B: begin
                ctrl.precompute_src_b = 1'b1;
                ctrl.load_3b          = adder_done;
            end
            S_DIGIT: begin
                ctrl.loop_mode = 1'b1;
                ctrl.sel       = {1'b0, digit};
                ctrl.shift_acc = 1'b1;
                ctrl.acc_en    = (count != '0);
                ctrl.shift_a   = adder_done;
            end
            S_REDUCE: begin
                ctrl.loop_mode = 1'b1;
                ctrl.sel       = red_sel;
                ctrl.acc_en    = 1'b1;
            end
            S_SUB_FIRST, S_SUB: begin
                ctrl.loop_mode = 1'b1;
                ctrl.sel       = SEL_M;
                ctrl.subtract  = 1'b1;
                ctrl.acc_en    = 1'b1;
                // last reduction still carries the pending divide by 4
                ctrl.shift_acc = (state == S_SUB_FIRST);
            end
            S_ADD_BACK: begin
                ctrl.loop_mode = 1'b1;
                ctrl.sel       = SEL_M;
                ctrl.acc_en    = 1'b1;
                ctrl.result_en = adder_done;
            end
            default: begin
            end
        endcase
    end

    assign done = (state == S_FINISH);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= S_IDLE;
            in_flight <= 1'b0;
            count     <= '0;
        end else begin
            state <= state_next;
            if (launch) begin
                in_flight <= 1'b1;
            end else if (adder_done) begin
                in_flight <= 1'b0;
            end
            if (state == S_IDLE) begin
                count <= '0;
            end else if (state == S_REDUCE && adder_done) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mont_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_top (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire                           start,
    input  wire mont_pkg::mont_operands_t ops,
    output wire [mont_pkg::WIDTH-1:0]     result,
    output wire                           done
);
    import mont_pkg::*;

    wire mont_ctrl_t  ctrl;
    wire acc_word_u   sum;
    wire              adder_done;
    wire [ACC_W-1:0]  op_a;
    wire [ACC_W-1:0]  op_b;
    wire [ACC_W-1:0]  multiple;
    wire [1:0]        digit;
    wire [1:0]        acc_low;

    mont_ctrl i_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .digit      (digit),
        .m_low      (ops.m[1:0]),
        .acc_low    (acc_low),
        .sum        (sum),
        .adder_done (adder_done),
        .ctrl       (ctrl),
        .done       (done)
    );

    mont_datapath i_datapath (
        .clk      (clk),
        .ctrl     (ctrl),
        .ops      (ops),
        .multiple (multiple),
        .sum      (sum),
        .op_a     (op_a),
        .op_b     (op_b),
        .digit    (digit),
        .acc_low  (acc_low),
        .result   (result)
    );

    multiple_table i_table (
        .clk      (clk),
        .ctrl     (ctrl),
        .b        (ops.b),
        .m        (ops.m),
        .sum      (sum),
        .multiple (multiple)
    );

    mp_adder i_adder (
        .clk        (clk),
        .resetn     (resetn),
        .start      (ctrl.adder_start),
        .subtract   (ctrl.subtract),
        .op_a       (op_a),
        .op_b       (op_b),
        .sum        (sum),
        .adder_done (adder_done)
    );

endmodule

`default_nettype wire

/* verif/mont_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_assert (
    input wire clk,
    input wire resetn,
    input wire adder_start,
    input wire adder_done,
    input wire done
);

    // adder busy for the two cycles after a launch
    a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        adder_start |=> !adder_start [*2])
        else $error("adder started while an addition was in flight");

    a_done_latency: assert property (@(posedge clk) disable iff (!resetn)
        adder_start |-> ##2 adder_done)
        else $error("adder_done missing two cycles after adder_start");

    a_done_source: assert property (@(posedge clk) disable iff (!resetn)
        adder_done |-> $past(adder_start, 2))
        else $error("adder_done without adder_start two cycles earlier");

    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind mont_ctrl mont_assert i_mont_assert (
    .clk         (clk),
    .resetn      (resetn),
    .adder_start (ctrl.adder_start),
    .adder_done  (adder_done),
    .done        (done)
);

`default_nettype wire

/* verif/mont_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_tb;
    import mont_pkg::*;

    localparam int RANDOM_OPS = 40;
    // zero operand, identity operand, largest operands, restart during a run
    localparam int DIRECTED_OPS = 4;
    localparam int CYCLES_PER_OP = 400;
    // one extra slot covers the quiet window after the restart case
    localparam int MAX_CYCLES = (RANDOM_OPS + DIRECTED_OPS + 1) * CYCLES_PER_OP;

    logic                 clk;
    logic                 resetn;
    logic                 start;
    mont_operands_t       ops;
    wire  [WIDTH-1:0]     result;
    wire                  done;

    integer seed;
    integer errors;
    integer checks;
    integer done_count;
    integer cycles;

    mont_top i_dut (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .ops    (ops),
        .result (result),
        .done   (done)
    );

    always #4 clk = ~clk;

    always @(negedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    // a*b*2^-WIDTH mod m by halving modulo m once per bit
    function automatic logic [WIDTH-1:0] mont_reference(
        input logic [WIDTH-1:0] a,
        input logic [WIDTH-1:0] b,
        input logic [WIDTH-1:0] m
    );
        logic [2*WIDTH-1:0] prod;
        logic [WIDTH:0]     r;
        prod = {{WIDTH{1'b0}}, a} * {{WIDTH{1'b0}}, b};
        r = (WIDTH + 1)'(prod % {{WIDTH{1'b0}}, m});
        for (int i = 0; i < WIDTH; i++) begin
            r = r[0] ? (r + {1'b0, m}) >> 1 : r >> 1;
        end
        return r[WIDTH-1:0];
    endfunction

    function automatic logic [WIDTH-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic run_operation(
        input logic [WIDTH-1:0] a,
        input logic [WIDTH-1:0] b,
        input logic [WIDTH-1:0] m,
        input bit               restart_midway,
        input logic [WIDTH-1:0] stray_a
    );
        logic [WIDTH-1:0] expected;
        integer           dones_before;
        integer           quiet_cycles;
        expected = mont_reference(a, b, m);
        dones_before = done_count;
        @(posedge clk);
        ops.a <= a;
        ops.b <= b;
        ops.m <= m;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (restart_midway) begin
            // operation is well under way here
            repeat (20) @(posedge clk);
            // an accepted restart would pick up this other a
            ops.a <= stray_a;
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        checks = checks + 2;
        if (result !== expected) begin
            errors = errors + 1;
            $display("Error at %0t ns: result %h, expected %h (a=%h b=%h m=%h)",
                     $time, result, expected, a, b, m);
        end
        if (result >= m) begin
            errors = errors + 1;
            $display("Error at %0t ns: result %h not reduced below m %h", $time, result, m);
        end
        // a stray accepted start would bring a second done within this window
        quiet_cycles = restart_midway ? CYCLES_PER_OP : 4;
        repeat (quiet_cycles) @(posedge clk);
        @(negedge clk);
        checks = checks + 1;
        if (done_count != dones_before + 1) begin
            errors = errors + 1;
            $display("Error at %0t ns: %0d done pulses for one accepted start",
                     $time, done_count - dones_before);
        end
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [WIDTH-1:0] m;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] a_stray;
        logic [WIDTH:0]   r_mod_m;
        clk = 1'b0;
        resetn = 1'b0;
        start = 1'b0;
        ops = '0;
        seed = 75382;
        errors = 0;
        checks = 0;
        done_count = 0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;

        // no done expected while idle after reset
        repeat (10) begin
            @(negedge clk);
            checks = checks + 1;
            if (done) begin
                errors = errors + 1;
                $display("done went high at %0t ns although no operation was started", $time);
            end
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            m = random_word() | {1'b1, {(WIDTH - 2){1'b0}}, 1'b1};
            a = random_word() % m;
            b = random_word() % m;
            run_operation(a, b, m, 1'b0, '0);
        end

        m = random_word() | {1'b1, {(WIDTH - 2){1'b0}}, 1'b1};
        b = random_word() % m;
        run_operation('0, b, m, 1'b0, '0);
        // 2^WIDTH mod m is the Montgomery form of one
        r_mod_m = {1'b1, {WIDTH{1'b0}}} % {1'b0, m};
        run_operation(r_mod_m[WIDTH-1:0], b, m, 1'b0, '0);
        run_operation(m - 1'b1, m - 1'b1, m, 1'b0, '0);
        a = random_word() % m;
        a_stray = random_word() % m;
        run_operation(a, b, m, 1'b1, a_stray);

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* montgomery_mult.f */
logic/mont_pkg.sv
logic/mp_adder.sv
logic/multiple_table.sv
logic/mont_datapath.sv
logic/mont_ctrl.sv
logic/mont_top.sv
verif/mont_assert.sv
verif/mont_tb.sv
